// File: build.f
+incdir+include
rtl/core_pkg.sv
rtl/core_ifs.sv
rtl/inst_decoder.sv
rtl/operand_fwd.sv
rtl/alu_exec.sv
rtl/writeback_port.sv
rtl/rv_stream_core.sv
tb/tb_rv_stream_core.sv

// File: tb/tb_rv_stream_core.sv
`timescale 1ns/100ps
`include "core_params.svh"

module tb_rv_stream_core import core_pkg::*; ();

	localparam logic [6:0] OPC_STORE = 7'h23;  // Unsupported opcode
	localparam logic [6:0] OPC_JAL   = 7'h6f;  // Unsupported opcode
	localparam int PASSES = 2;                 // Ready held high then random

	logic      CLK;
	logic      arst_n;
	logic      in_valid;
	logic      in_ready;
	inst_t     in_inst;
	logic      out_valid;
	logic      out_ready;
	reg_addr_t out_rd;
	word_t     out_data;

	// Stimulus table with one row per instruction
	inst_t     step_inst[$];
	logic      step_has[$];     // Row produces a result
	reg_addr_t step_rd[$];
	word_t     step_data[$];

	// Results still owed by the DUT in arrival order
	reg_addr_t exp_rd_q[$];
	word_t     exp_data_q[$];

	int        sent_res = 0;
	int        rcv_count = 0;
	logic      table_built = 1'b0;
	logic      random_ready = 1'b0;
	integer    seed = 32'hcebb;

	rv_stream_core i_dut (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_inst   (in_inst),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_rd    (out_rd),
		.out_data  (out_data)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0d ns: %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_rd(input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp) begin
			$display("Error at %0d ns: out_rd got %0d expected %0d", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_data(input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Error at %0d ns: out_data got 0x%08h expected 0x%08h", $time, got, exp);
			abort_run();
		end
	endtask

	// Instruction encoders
	function automatic inst_t imm_op(input logic [11:0] imm, input reg_addr_t rs1,
			input logic [2:0] f3, input reg_addr_t rd);
		return {imm, rs1, f3, rd, `CORE_OPC_OP_IMM};
	endfunction

	function automatic inst_t reg_op(input logic [6:0] f7, input reg_addr_t rs2,
			input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, `CORE_OPC_OP};
	endfunction

	function automatic inst_t lui_op(input logic [19:0] imm, input reg_addr_t rd);
		return {imm, rd, `CORE_OPC_LUI};
	endfunction

	task automatic add_step(input inst_t inst, input logic has, input reg_addr_t rd,
			input word_t data);
		step_inst.push_back(inst);
		step_has.push_back(has);
		step_rd.push_back(rd);
		step_data.push_back(data);
	endtask

	// Expected values by hand from RV32I with all registers starting at zero
	task automatic build_table();
		add_step(lui_op(20'h12345, 1), 1, 1, 32'h12345000);
		add_step(imm_op(12'h678, 1, 3'b000, 2), 1, 2, 32'h12345678);   // Fwd from LUI
		add_step(imm_op(12'hffb, 0, 3'b000, 3), 1, 3, 32'hfffffffb);   // ADDI -5
		add_step(imm_op(12'hffc, 3, 3'b010, 4), 1, 4, 32'h00000001);   // -5 < -4
		add_step(imm_op(12'hffc, 3, 3'b011, 5), 1, 5, 32'h00000001);   // Imm sign extended
		add_step(imm_op(12'h005, 3, 3'b011, 6), 1, 6, 32'h00000000);
		add_step(imm_op(12'hfff, 2, 3'b100, 7), 1, 7, 32'hedcba987);   // XORI -1 inverts
		add_step(imm_op(12'h0f0, 1, 3'b110, 8), 1, 8, 32'h123450f0);
		add_step(imm_op(12'h0ff, 2, 3'b111, 9), 1, 9, 32'h00000078);
		add_step(imm_op(12'h004, 2, 3'b001, 10), 1, 10, 32'h23456780);
		add_step(imm_op(12'h004, 3, 3'b101, 11), 1, 11, 32'h0fffffff);
		add_step(imm_op(12'h401, 3, 3'b101, 12), 1, 12, 32'hfffffffd);  // SRAI
		// R-type
		add_step(reg_op(7'h00, 3, 2, 3'b000, 13), 1, 13, 32'h12345673);
		add_step(reg_op(7'h20, 2, 9, 3'b000, 14), 1, 14, 32'hedcbaa00);  // Underflow
		add_step(reg_op(7'h00, 2, 3, 3'b010, 15), 1, 15, 32'h00000001);  // Signed
		add_step(reg_op(7'h00, 2, 3, 3'b011, 16), 1, 16, 32'h00000000);  // Unsigned
		add_step(reg_op(7'h00, 2, 1, 3'b100, 17), 1, 17, 32'h00000678);
		add_step(reg_op(7'h00, 10, 9, 3'b110, 18), 1, 18, 32'h234567f8);
		add_step(reg_op(7'h00, 2, 7, 3'b111, 19), 1, 19, 32'h00000000);
		add_step(reg_op(7'h00, 4, 9, 3'b001, 20), 1, 20, 32'h000000f0);
		add_step(reg_op(7'h00, 5, 7, 3'b101, 21), 1, 21, 32'h76e5d4c3);
		add_step(reg_op(7'h20, 5, 7, 3'b101, 22), 1, 22, 32'hf6e5d4c3);  // SRA negative
		// Dependent chain
		add_step(imm_op(12'h007, 0, 3'b000, 24), 1, 24, 32'h00000007);
		add_step(reg_op(7'h00, 24, 24, 3'b000, 25), 1, 25, 32'h0000000e);
		add_step(reg_op(7'h00, 24, 25, 3'b000, 26), 1, 26, 32'h00000015);
		add_step(reg_op(7'h20, 25, 26, 3'b000, 27), 1, 27, 32'h00000007);
		// x0 write is output but reads of x0 stay zero
		add_step(imm_op(12'h055, 0, 3'b000, 0), 1, 0, 32'h00000055);
		add_step(reg_op(7'h00, 24, 0, 3'b000, 28), 1, 28, 32'h00000007);
		add_step(imm_op(12'h003, 0, 3'b000, 29), 1, 29, 32'h00000003);
		// Bubbles around dependent ops
		add_step({7'h00, 5'd24, 5'd25, 3'b010, 5'd0, OPC_STORE}, 0, 0, '0);  // SW
		add_step(reg_op(7'h00, 28, 29, 3'b000, 30), 1, 30, 32'h0000000a);
		add_step({20'h00100, 5'd30, OPC_JAL}, 0, 0, '0);  // rd field hits x30
		add_step(imm_op(12'h001, 30, 3'b000, 31), 1, 31, 32'h0000000b);
	endtask

	// Hold inst on the port until the DUT takes it
	task automatic drive_inst(input inst_t inst);
		logic taken;
		in_valid = 1'b1;
		in_inst  = inst;
		taken    = 1'b0;
		while (!taken) begin
			@(negedge CLK);
			taken = in_ready;   // Transfer on the coming edge
			@(posedge CLK);
			#2;
		end
	endtask

	task automatic run_table();
		for (int i = 0; i < step_inst.size(); i++) begin
			if (step_has[i]) begin
				exp_rd_q.push_back(step_rd[i]);
				exp_data_q.push_back(step_data[i]);
				sent_res++;
			end
			drive_inst(step_inst[i]);
		end
		in_valid = 1'b0;
	endtask

	// Output back-pressure
	initial begin : ready_gen
		logic [31:0] rnd;
		out_ready = 1'b1;
		forever begin
			@(posedge CLK);
			#2;
			rnd = $random(seed);
			out_ready = random_ready ? rnd[0] : 1'b1;
		end
	end

	// Sampled mid-cycle where inputs have settled
	always @(negedge CLK) begin
		if (arst_n) begin
			check_flag("in_ready", in_ready, !(out_valid && !out_ready));
			if (out_valid && out_ready) begin
				if (exp_rd_q.size() == 0) begin
					$display("Result for x%0d arrived with no result pending", out_rd);
					abort_run();
				end else begin
					check_rd(out_rd, exp_rd_q.pop_front());
					check_data(out_data, exp_data_q.pop_front());
					rcv_count++;
				end
			end
		end
	end

	initial begin : watchdog
		int limit_ns;
		wait (table_built);
		limit_ns = PASSES * step_inst.size() * 40 * 20;
		#(limit_ns);
		$display("Timeout after %0d ns with %0d of %0d results received",
			limit_ns, rcv_count, sent_res);
		abort_run();
	end

	initial begin : main_seq
		in_valid = 1'b0;
		in_inst  = '0;
		arst_n   = 1'b0;
		build_table();
		table_built = 1'b1;
		repeat (8) @(posedge CLK);
		#2;
		arst_n = 1'b1;

		// Idle state after reset
		@(negedge CLK);
		check_flag("in_ready", in_ready, 1'b1);
		check_flag("out_valid", out_valid, 1'b0);
		@(posedge CLK);
		#2;

		run_table();             // Back to back with ready held high
		@(negedge CLK);
		random_ready = 1'b1;
		@(posedge CLK);
		#2;
		run_table();             // Same rows under back-pressure

		wait (rcv_count == sent_res);
		repeat (10) @(negedge CLK);  // Nothing extra may follow

		if (out_valid === 1'b0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("Output still valid after all %0d expected results", sent_res);
			abort_run();
		end
	end

endmodule

// File: rtl/rv_stream_core.sv
`timescale 1ns/100ps

module rv_stream_core import core_pkg::*; (
	input              CLK,
	input              arst_n,

	// Instruction stream
	input  logic       in_valid,
	output logic       in_ready,
	input  inst_t      in_inst,

	// Result stream
	output logic       out_valid,
	input  logic       out_ready,
	output reg_addr_t  out_rd,
	output word_t      out_data
);

	logic      stall;       // Whole pipeline holds
	word_t     exe_result;
	logic      wb_en;
	logic      wb_pending;
	reg_addr_t wb_rd;
	word_t     wb_data;

	dec_if dec_bus ();
	exe_if exe_bus ();

	// Output back-pressure freezes every stage
	assign stall    = out_valid && !out_ready;
	assign in_ready = !stall;

	inst_decoder i_decoder (
		.CLK      (CLK),
		.arst_n   (arst_n),
		.stall    (stall),
		.in_valid (in_valid),
		.in_inst  (in_inst),
		.dec      (dec_bus.src)
	);

	operand_fwd i_fwd (
		.CLK        (CLK),
		.arst_n     (arst_n),
		.stall      (stall),
		.dec        (dec_bus.dst),
		.exe        (exe_bus.src),
		.exe_result (exe_result),   // exe -> id path
		.wb_en      (wb_en),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data),
		.wb_pending (wb_pending)
	);

	alu_exec i_alu (
		.exe    (exe_bus.dst),
		.result (exe_result)
	);

	writeback_port i_wb (
		.CLK        (CLK),
		.arst_n     (arst_n),
		.stall      (stall),
		.exe        (exe_bus.dst),
		.result     (exe_result),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_rd     (out_rd),
		.out_data   (out_data),
		.wb_en      (wb_en),
		.wb_pending (wb_pending),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data)
	);

endmodule

// File: rtl/writeback_port.sv
`timescale 1ns/100ps

module writeback_port import core_pkg::*; (
	input              CLK,
	input              arst_n,
	input  logic       stall,
	exe_if.dst         exe,
	input  word_t      result,      // ALU output for the execute instruction
	output logic       out_valid,
	input  logic       out_ready,
	output reg_addr_t  out_rd,
	output word_t      out_data,
	output logic       wb_en,       // Register file write
	output logic       wb_pending,  // Result held, not yet in register file
	output reg_addr_t  wb_rd,
	output word_t      wb_data
);

	logic      vld_q;
	reg_addr_t rd_q;
	word_t     data_q;
	logic      take;   // Writing instruction leaves execute

	assign take = exe.valid && exe.wr;

	// Result register valid
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			vld_q <= 1'b0;
		end else if (!stall) begin
			vld_q <= take;  // Drops after transfer unless refilled
		end
	end

	// Result payload
	always_ff @(posedge CLK) begin
		if (!stall && take) begin
			rd_q   <= exe.rd;
			data_q <= result;
		end
	end

	// Output side
	assign out_valid = vld_q;
	assign out_rd    = rd_q;
	assign out_data  = data_q;

	// Register file side, written on the output transfer
	assign wb_en      = vld_q && out_ready;
	assign wb_pending = vld_q;
	assign wb_rd      = rd_q;
	assign wb_data    = data_q;

endmodule

// File: rtl/alu_exec.sv
`timescale 1ns/100ps

module alu_exec import core_pkg::*; (
	exe_if.dst         exe,
	output word_t      result
);

	logic [4:0] shamt;   // RV32I shift amount

	assign shamt = exe.op_b[4:0];

	always_comb begin
		case (exe.alu_op)
			ALU_ADD: result = exe.op_a + exe.op_b;
			ALU_SUB: result = exe.op_a - exe.op_b;   // Wraps on underflow
			ALU_SLL: result = exe.op_a << shamt;
			ALU_SRL: result = exe.op_a >> shamt;

			// Arithmetic shift keeps the sign bit
			ALU_SRA: result = word_t'($signed(exe.op_a) >>> shamt);

			// Compares give 0 or 1
			ALU_SLT: result = word_t'($signed(exe.op_a) < $signed(exe.op_b));
			ALU_SLTU: result = word_t'(exe.op_a < exe.op_b);

			ALU_XOR: result = exe.op_a ^ exe.op_b;
			ALU_OR: result = exe.op_a | exe.op_b;
			ALU_AND: result = exe.op_a & exe.op_b;
			ALU_PASS_B: result = exe.op_b;           // LUI
			default: result = '0;
		endcase
	end

endmodule

// File: rtl/operand_fwd.sv
`timescale 1ns/100ps
`include "core_params.svh"

module operand_fwd import core_pkg::*; (
	input              CLK,
	input              arst_n,
	input  logic       stall,
	dec_if.dst         dec,
	exe_if.src         exe,
	input  word_t      exe_result,   // ALU output, first forwarding source
	input  logic       wb_en,        // Register file write strobe
	input  reg_addr_t  wb_rd,
	input  word_t      wb_data,
	input  logic       wb_pending    // Result register not yet written
);

	word_t     rf [`CORE_REG_COUNT];  // Register file, x0 stays zero
	word_t     fwd_a;
	word_t     fwd_b;
	word_t     opb_sel;
	logic      exe_fwd_ok;           // Execute stage carries a register write

	// Execute register
	logic      valid_q;
	logic      wr_q;
	reg_addr_t rd_q;
	word_t     op_a_q;
	word_t     op_b_q;
	alu_op_e   alu_op_q;

	// Register file write on output transfer
	// Cleared on reset so reads start from zero
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CORE_REG_COUNT; i++) begin
				rf[i] <= '0;
			end
		end else if (wb_en && (wb_rd != '0)) begin
			rf[wb_rd] <= wb_data;
		end
	end

	assign exe_fwd_ok = valid_q && wr_q;

	// Operand pick, execute result ahead of the result register
	function automatic word_t fwd_pick(input reg_addr_t rs, input word_t rf_val);
		word_t val;
		if (rs == '0) begin
			val = rf_val;                        // x0, never forwarded
		end else if (exe_fwd_ok && (rd_q == rs)) begin
			val = exe_result;                    // exe -> id
		end else if (wb_pending && (wb_rd == rs)) begin
			val = wb_data;                       // wb -> id
		end else begin
			val = rf_val;
		end
		return val;
	endfunction

	always_comb begin
		fwd_a = fwd_pick(dec.rs1, rf[dec.rs1]);
		fwd_b = fwd_pick(dec.rs2, rf[dec.rs2]);
	end

	assign opb_sel = dec.use_imm ? dec.imm : fwd_b;  // I-type and LUI

	// Execute register control
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
			wr_q    <= 1'b0;
		end else if (!stall) begin
			valid_q <= dec.valid;
			wr_q    <= dec.wr;
		end
	end

	// Execute register payload
	always_ff @(posedge CLK) begin
		if (!stall) begin
			rd_q     <= dec.rd;
			op_a_q   <= fwd_a;
			op_b_q   <= opb_sel;
			alu_op_q <= dec.alu_op;
		end
	end

	assign exe.valid  = valid_q;
	assign exe.wr     = wr_q;
	assign exe.rd     = rd_q;
	assign exe.op_a   = op_a_q;
	assign exe.op_b   = op_b_q;
	assign exe.alu_op = alu_op_q;

endmodule

// File: rtl/inst_decoder.sv
`timescale 1ns/100ps
`include "core_params.svh"

module inst_decoder import core_pkg::*; (
	input              CLK,
	input              arst_n,
	input  logic       stall,     // Global freeze
	input  logic       in_valid,
	input  inst_t      in_inst,
	dec_if.src         dec
);

	logic       in_q_valid;   // Intake register holds an instruction
	inst_t      in_q;         // Intake register
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       alt;          // inst[30], picks SUB / SRA
	word_t      imm_i;
	word_t      imm_u;
	alu_op_e    op_sel;
	logic       wr_sel;
	logic       imm_sel;
	word_t      imm_mux;

	// Shared funct3 map for R-type and I-type
	// SUB only exists in R-type, SRA/SRAI in both
	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic bit30,
			input logic is_reg);
		alu_op_e op;
		case (f3)
			3'b000: begin
				if (is_reg && bit30) op = ALU_SUB;
				else op = ALU_ADD;
			end
			3'b001: op = ALU_SLL;
			3'b010: op = ALU_SLT;
			3'b011: op = ALU_SLTU;
			3'b100: op = ALU_XOR;
			3'b101: begin
				if (bit30) op = ALU_SRA;
				else op = ALU_SRL;
			end
			3'b110: op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	// Intake valid
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			in_q_valid <= 1'b0;
		end else if (!stall) begin
			in_q_valid <= in_valid;  // Empty slot when no input
		end
	end

	// Intake payload, loaded on input transfer only
	always_ff @(posedge CLK) begin
		if (!stall && in_valid) begin
			in_q <= in_inst;
		end
	end

	assign opcode = in_q[6:0];
	assign funct3 = in_q[14:12];
	assign alt    = in_q[30];

	// Immediates
	assign imm_i = {{20{in_q[31]}}, in_q[31:20]};  // Sign extended
	assign imm_u = {in_q[31:12], 12'h000};

	always_comb begin
		wr_sel  = 1'b1;
		imm_sel = 1'b1;
		imm_mux = imm_i;
		op_sel  = ALU_ADD;
		case (opcode)
			`CORE_OPC_OP: begin
				imm_sel = 1'b0;                       // rs2 operand
				op_sel  = arith_op(funct3, alt, 1'b1);
			end
			`CORE_OPC_OP_IMM: op_sel = arith_op(funct3, alt, 1'b0);
			`CORE_OPC_LUI: begin
				imm_mux = imm_u;
				op_sel  = ALU_PASS_B;
			end
			default: wr_sel = 1'b0;                   // Dropped as a bubble
		endcase
	end

	assign dec.valid   = in_q_valid && wr_sel;
	assign dec.wr      = wr_sel;
	assign dec.rd      = in_q[11:7];
	assign dec.rs1     = in_q[19:15];
	assign dec.rs2     = in_q[24:20];
	assign dec.use_imm = imm_sel;
	assign dec.imm     = imm_mux;
	assign dec.alu_op  = op_sel;

endmodule

// File: rtl/core_ifs.sv
`timescale 1ns/100ps

// Decode to operand stage
interface dec_if import core_pkg::*; ();
	logic      valid;    // Supported instruction in decode
	logic      wr;       // Writes rd
	reg_addr_t rd;
	reg_addr_t rs1;
	reg_addr_t rs2;
	logic      use_imm;  // Immediate replaces rs2 operand
	word_t     imm;      // I-type or U-type immediate
	alu_op_e   alu_op;

	modport src (
		output valid, wr, rd, rs1, rs2, use_imm, imm, alu_op
	);

	modport dst (
		input valid, wr, rd, rs1, rs2, use_imm, imm, alu_op
	);
endinterface

// Execute register contents
// Read by the ALU and by the writeback stage
interface exe_if import core_pkg::*; ();
	logic      valid;
	logic      wr;
	reg_addr_t rd;
	word_t     op_a;     // Forwarded rs1
	word_t     op_b;     // Forwarded rs2 or immediate
	alu_op_e   alu_op;

	modport src (
		output valid, wr, rd, op_a, op_b, alu_op
	);

	modport dst (
		input valid, wr, rd, op_a, op_b, alu_op
	);
endinterface

// File: rtl/core_pkg.sv
`include "core_params.svh"

package core_pkg;

	// One data word of the execute path
	typedef logic [`CORE_XLEN-1:0] word_t;

	// Raw instruction word, always 32 bits in RV32I
	typedef logic [31:0] inst_t;

	// Register index
	typedef logic [`CORE_REG_ADDR_W-1:0] reg_addr_t;

	// ALU operation
	// Encoding follows {funct7[5], funct3} for the ISA operations
	typedef enum logic [3:0] {
		ALU_ADD    = 4'b0000,
		ALU_SLL    = 4'b0001,
		ALU_SLT    = 4'b0010,
		ALU_SLTU   = 4'b0011,
		ALU_XOR    = 4'b0100,
		ALU_SRL    = 4'b0101,
		ALU_OR     = 4'b0110,
		ALU_AND    = 4'b0111,
		ALU_SUB    = 4'b1000,
		ALU_SRA    = 4'b1101,
		ALU_PASS_B = 4'b1111  // LUI, immediate straight through
	} alu_op_e;

endpackage

// File: include/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath widths
`define CORE_XLEN        32
`define CORE_REG_COUNT   32
`define CORE_REG_ADDR_W  5

// Major opcodes the decoder keeps
`define CORE_OPC_OP      7'h33  // R-type ALU
`define CORE_OPC_OP_IMM  7'h13  // I-type ALU
`define CORE_OPC_LUI     7'h37  // Upper immediate

`endif
